//--- rcn_ring_top.f
source/rcn_pkg.sv
source/rcn_master.sv
source/rcn_ram.sv
source/rcn_ring_top.sv
+incdir+bench
bench/rcn_ring_tb.sv

//--- Makefile
# Verilator build and run of the ring testbench.
TOP = rcn_ring_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f rcn_ring_top.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- bench/rcn_ring_checks.svh
/* Compare tasks and model helpers for rcn_ring_tb. Included inside the testbench
   module after its counters and model memory; needs rcn_pkg imported. */
`ifndef RCN_RING_CHECKS_SVH
`define RCN_RING_CHECKS_SVH

// one expected completion, in issue order.
typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [1:0]        seq;
    logic [31:0]       cycle;  // edge that accepted the request.
} expect_t;

task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input logic [ADDR_W-1:0] a);
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t: rdata %h for addr %h, expected %h", $time, got, a, exp);
    end
endtask

task automatic check_status(input logic got_err, input logic [1:0] got_seq,
                            input logic exp_err, input logic [1:0] exp_seq);
    if (got_err !== exp_err) begin
        mismatches++;
        $display("Mismatch at %0t: err %b, expected %b", $time, got_err, exp_err);
    end
    if (got_seq !== exp_seq) begin
        mismatches++;
        $display("Mismatch at %0t: seq %0d, expected %0d", $time, got_seq, exp_seq);
    end
endtask

task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t: busy %b, expected %b", $time, got, exp);
    end
endtask

task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
        mismatches++;
        $display("Mismatch at %0t: done after %0d cycles, expected %0d", $time, got, exp);
    end
endtask

function automatic logic in_window(input logic [ADDR_W-1:0] a);
    int lo;
    int hi;
    lo = int'(RAM_BASE);
    hi = lo + NUM_RAMS * int'(RAM_STRIDE);
    return (int'(a) >= lo) && (int'(a) < hi);
endfunction

function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                  input logic [DATA_W-1:0] wdat,
                                                  input logic [3:0] m);
    logic [DATA_W-1:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
        if (m[b]) begin
            r[8*b +: 8] = wdat[8*b +: 8];
        end
    end
    return r;
endfunction

// applies the request to the model memory and returns what done should show.
function automatic expect_t predict(input logic w, input logic [ADDR_W-1:0] a,
                                    input logic [3:0] m, input logic [DATA_W-1:0] d,
                                    input logic [1:0] t, input logic [31:0] c);
    expect_t e;
    logic [DATA_W-1:0] old;
    e.addr  = a;
    e.seq   = t;
    e.cycle = c;
    if (!in_window(a)) begin
        e.err   = 1'b1;  // nobody claims it.
        e.rdata = '0;
    end else begin
        old   = model_mem.exists(int'(a)) ? model_mem[int'(a)] : '0;
        e.err = 1'b0;
        if (w) begin
            e.rdata = merge_bytes(old, d, m);
            model_mem[int'(a)] = e.rdata;
        end else begin
            e.rdata = old;
        end
    end
    return e;
endfunction

`endif

//--- bench/rcn_ring_tb.sv
/* Random traffic through the ring, checked against a word memory model.
   Requests are issued at a rising edge; outputs are sampled on the falling edge. */
module rcn_ring_tb;
    import rcn_pkg::*;

    localparam int BUSY_LIMIT   = 64;
    localparam int DRAIN_LIMIT  = 400;
    localparam int RANDOM_COUNT = 600;
    localparam int WINDOW_WORDS = NUM_RAMS << RAM_ADDR_BITS;
    localparam logic [3:0] MASKS [0:5] = '{4'hf, 4'h1, 4'h4, 4'ha, 4'h6, 4'h9};

    logic               clk;
    logic               rst;
    logic               cs;
    logic               wr;
    logic [ADDR_W-1:0]  addr;
    logic [3:0]         mask;
    logic [DATA_W-1:0]  wdata;
    logic               busy;
    logic               done;
    logic [DATA_W-1:0]  rdata;
    logic [1:0]         seq;
    logic               err;

    int                 mismatches;
    int                 failures;
    int                 accepted;
    int                 completed;
    int                 seed;
    logic               timed_out;
    logic [31:0]        cycle;
    logic [1:0]         next_tag;
    logic [DATA_W-1:0]  model_mem [int];

    `include "rcn_ring_checks.svh"

    expect_t            pending [$];

    rcn_ring_top uut (
        .clk(clk),
        .rst(rst),
        .cs(cs),
        .wr(wr),
        .addr(addr),
        .mask(mask),
        .wdata(wdata),
        .busy(busy),
        .done(done),
        .rdata(rdata),
        .seq(seq),
        .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    // falling edge: completions first, then the request the next edge takes.
    always @(negedge clk) begin : monitor
        expect_t e;
        if (!rst) begin
            if (done) begin
                if (pending.size() == 0) begin
                    failures++;
                    $display("done pulse at %0t with no request outstanding", $time);
                end else begin
                    e = pending.pop_front();
                    check_data(rdata, e.rdata, e.addr);
                    check_status(err, seq, e.err, e.seq);
                    check_latency(int'(cycle - e.cycle), RING_LATENCY);
                    completed++;
                end
            end
            // busy follows the outstanding count alone on a single-master ring.
            check_busy(busy, pending.size() == MAX_INFLIGHT);
            if (cs && !busy) begin
                pending.push_back(predict(wr, addr, mask, wdata, next_tag, cycle + 32'd1));
                next_tag = next_tag + 2'd1;
                accepted++;
                if (pending.size() > MAX_INFLIGHT) begin
                    failures++;
                    $display("more than %0d requests outstanding at %0t", MAX_INFLIGHT, $time);
                end
            end
        end
    end

    function automatic int rnd_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input int offset);
        return ADDR_W'(int'(RAM_BASE) + offset);
    endfunction

    // called at a rising edge, returns at the edge that accepts the request.
    task automatic issue(input logic w, input logic [ADDR_W-1:0] a, input logic [3:0] m,
                         input logic [DATA_W-1:0] d);
        int waited;
        waited = 0;
        if (!timed_out) begin
            cs    <= 1'b1;
            wr    <= w;
            addr  <= a;
            mask  <= m;
            wdata <= d;
            @(negedge clk);
            while (busy && !timed_out) begin
                waited++;
                if (waited > BUSY_LIMIT) begin
                    timed_out = 1'b1;
                    failures++;
                    $display("busy stayed high for %0d cycles, request not accepted", waited);
                end else begin
                    @(negedge clk);
                end
            end
            @(posedge clk);
            cs <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                timed_out = 1'b1;
                failures++;
                $display("%0d requests never completed", pending.size());
            end
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [3:0]        m;
        logic              w;
        seed       = 64273;
        mismatches = 0;
        failures   = 0;
        accepted   = 0;
        completed  = 0;
        timed_out  = 1'b0;
        cycle      = '0;
        next_tag   = '0;
        rst   = 1'b1;
        cs    = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        mask  = '0;
        wdata = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // every word of every node starts at zero.
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            issue(1'b0, word_addr(i), 4'h0, '0);
        end

        // masked writes on one word per node, each read back.
        for (int n = 0; n < NUM_RAMS; n++) begin
            a = word_addr(n * int'(RAM_STRIDE) + rnd_below(1 << RAM_ADDR_BITS));
            for (int k = 0; k < 6; k++) begin
                d = $random(seed);
                issue(1'b1, a, MASKS[k], d);
                issue(1'b0, a, 4'h0, '0);
            end
        end

        // unclaimed addresses, then a word written above must still be intact.
        issue(1'b0, 22'h000000, 4'h0, '0);
        issue(1'b1, word_addr(-1), 4'hf, 32'hdeadbeef);
        issue(1'b1, word_addr(WINDOW_WORDS), 4'hf, 32'h12345678);
        issue(1'b0, word_addr(WINDOW_WORDS), 4'h0, '0);
        issue(1'b0, 22'h3fffff, 4'h0, '0);
        issue(1'b0, a, 4'h0, '0);

        // back-to-back mix, roughly one in sixteen outside every window.
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            if (rnd_below(16) == 0) begin
                a = word_addr(WINDOW_WORDS + rnd_below(4096));
            end else begin
                a = word_addr(rnd_below(WINDOW_WORDS));
            end
            w = (rnd_below(2) == 1);
            m = 4'(rnd_below(16));
            d = $random(seed);
            issue(w, a, m, d);
            if (rnd_below(8) == 0) begin
                repeat (rnd_below(3)) @(posedge clk);
            end
        end

        drain();
        repeat (2 * RING_LATENCY) @(posedge clk);  // any stray done shows up here.
        if (completed != accepted) begin
            failures++;
            $display("%0d requests accepted but %0d completed", accepted, completed);
        end

        $display("completed %0d, mismatches %0d, other failures %0d",
                 completed, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- source/rcn_ring_top.sv
/* Ring of one master and NUM_RAMS RAM nodes. Node windows are contiguous from
   RAM_BASE; addresses elsewhere return err. */
module rcn_ring_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        cs,
    input  logic                        wr,
    input  logic [rcn_pkg::ADDR_W-1:0]  addr,
    input  logic [3:0]                  mask,
    input  logic [rcn_pkg::DATA_W-1:0]  wdata,
    output logic                        busy,

    output logic                        done,
    output logic [rcn_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                  seq,
    output logic                        err
);
    import rcn_pkg::*;

    // ring[0] leaves the master, ring[NUM_RAMS] comes back to it.
    rcn_pkt_t ring [0:NUM_RAMS];

    rcn_master master (
        .clk(clk),
        .rst(rst),

        .cs(cs),
        .wr(wr),
        .addr(addr),
        .mask(mask),
        .wdata(wdata),
        .busy(busy),

        .done(done),
        .rdata(rdata),
        .seq(seq),
        .err(err),

        .rcn_in(ring[NUM_RAMS]),
        .rcn_out(ring[0])
    );

    for (genvar i = 0; i < NUM_RAMS; i++) begin : g_ram
        rcn_ram #(.ADDR_BASE(ADDR_W'(RAM_BASE + RAM_STRIDE * i))) sram (
            .clk(clk),
            .rst(rst),

            .rcn_in(ring[i]),
            .rcn_out(ring[i+1])
        );
    end

endmodule

//--- source/rcn_ram.sv
/* RAM node, one hop of latency. Claims requests inside its own window only;
   contents start at zero and are not cleared by rst. */
module rcn_ram #(
    parameter logic [rcn_pkg::ADDR_W-1:0] ADDR_BASE = '0
) (
    input  logic               clk,
    input  logic               rst,

    input  rcn_pkg::rcn_pkt_t  rcn_in,
    output rcn_pkg::rcn_pkt_t  rcn_out
);
    import rcn_pkg::*;

    localparam int DEPTH = 1 << RAM_ADDR_BITS;

    logic [DATA_W-1:0]         mem [0:DEPTH-1];
    logic [RAM_ADDR_BITS-1:0]  idx;
    logic                      hit;
    logic [DATA_W-1:0]         rd_word;
    logic [DATA_W-1:0]         merged;
    rcn_pkt_t                  out_d;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign idx = rcn_in.addr[RAM_ADDR_BITS-1:0];

    // upper address bits select the node.
    assign hit = rcn_in.valid && rcn_in.req &&
                 (rcn_in.addr[ADDR_W-1:RAM_ADDR_BITS] ==
                  ADDR_BASE[ADDR_W-1:RAM_ADDR_BITS]);

    assign rd_word = mem[idx];

    always_comb begin
        merged = rd_word;
        for (int b = 0; b < 4; b++) begin
            if (rcn_in.mask[b]) begin
                merged[8*b +: 8] = rcn_in.data[8*b +: 8];
            end
        end
    end

    always_comb begin
        out_d = rcn_in;  // anything not ours passes untouched.
        if (hit) begin
            out_d.req  = 1'b0;
            out_d.data = rcn_in.wr ? merged : rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (hit && rcn_in.wr) begin
            mem[idx] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rcn_out <= '0;
        end else begin
            rcn_out <= out_d;
        end
    end

    // a node answers in its slot, it never creates traffic of its own.
    a_no_spawn: assert property (
        @(posedge clk) disable iff (rst)
        !rcn_in.valid |=> !rcn_out.valid
    );

endmodule

//--- source/rcn_master.sv
/* Sole master of the ring. Holds at most MAX_INFLIGHT requests; cs must be held
   while busy is high. Done pulses come back in issue order. */
module rcn_master (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        cs,
    input  logic                        wr,
    input  logic [rcn_pkg::ADDR_W-1:0]  addr,
    input  logic [3:0]                  mask,
    input  logic [rcn_pkg::DATA_W-1:0]  wdata,
    output logic                        busy,

    output logic                        done,
    output logic [rcn_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                  seq,
    output logic                        err,

    input  rcn_pkg::rcn_pkt_t           rcn_in,
    output rcn_pkg::rcn_pkt_t           rcn_out
);
    import rcn_pkg::*;

    localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);

    rcn_pkt_t          in_q;
    rcn_pkt_t          req_pkt;
    rcn_pkt_t          out_d;
    logic [CNT_W-1:0]  inflight;
    logic [1:0]        tag;
    logic              mine;
    logic              foreign;
    logic              accept;

    // returning slot is registered before the master looks at it.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_q <= '0;
        end else begin
            in_q <= rcn_in;
        end
    end

    assign mine    = in_q.valid && (in_q.id == MASTER_ID);
    assign foreign = in_q.valid && (in_q.id != MASTER_ID);

    // a foreign packet owns the outgoing slot this cycle.
    assign busy   = (inflight == CNT_W'(MAX_INFLIGHT)) || foreign;
    assign accept = cs && !busy;

    always_comb begin
        req_pkt       = '0;
        req_pkt.valid = 1'b1;
        req_pkt.req   = 1'b1;
        req_pkt.id    = MASTER_ID;
        req_pkt.wr    = wr;
        req_pkt.mask  = mask;
        req_pkt.seq   = tag;
        req_pkt.addr  = addr;
        req_pkt.data  = wr ? wdata : '0;  // reads carry no payload.
    end

    always_comb begin
        if (accept) begin
            out_d = req_pkt;
        end else if (foreign) begin
            out_d = in_q;
        end else begin
            out_d = '0;  // own packets are consumed, slot goes empty.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rcn_out <= '0;
        end else begin
            rcn_out <= out_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
            tag      <= '0;
        end else begin
            case ({accept, mine})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;  // both or neither.
            endcase
            if (accept) begin
                tag <= tag + 1'b1;  // wraps modulo 4.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
            err  <= 1'b0;
        end else begin
            done <= mine;
            err  <= mine && in_q.req;  // still a request, so nobody claimed it.
        end
    end

    always_ff @(posedge clk) begin
        if (mine) begin
            rdata <= in_q.req ? '0 : in_q.data;
            seq   <= in_q.seq;
        end
    end

    a_inflight_max: assert property (
        @(posedge clk) disable iff (rst)
        inflight <= CNT_W'(MAX_INFLIGHT)
    );

    // every consumed packet was issued earlier and is still counted.
    a_inflight_underflow: assert property (
        @(posedge clk) disable iff (rst)
        mine |-> (inflight != '0)
    );

endmodule

//--- source/rcn_pkg.sv
/* Ring packet layout and address map for a single-master ring of RAM nodes.
   Word addresses only; every node window is RAM_STRIDE words wide. */
package rcn_pkg;

    localparam int ADDR_W = 22;
    localparam int DATA_W = 32;

    // one ring slot, 69 bits wide, moves one hop per clock.
    typedef struct packed {
        logic              valid;  // slot occupied.
        logic              req;    // request when set, response when clear.
        logic [5:0]        id;     // issuing master.
        logic              wr;     // write access.
        logic [3:0]        mask;   // byte enables.
        logic [1:0]        seq;    // tag from the master.
        logic [ADDR_W-1:0] addr;   // word address.
        logic [DATA_W-1:0] data;   // write data or read result.
    } rcn_pkt_t;

    localparam logic [5:0] MASTER_ID = 6'd0;

    localparam int NUM_RAMS = 4;

    // words per node is 2**RAM_ADDR_BITS.
    localparam int RAM_ADDR_BITS = 8;

    // node 0 sits here, the rest follow at RAM_STRIDE spacing.
    localparam logic [ADDR_W-1:0] RAM_BASE = 22'h001000;
    localparam logic [ADDR_W-1:0] RAM_STRIDE = ADDR_W'(1) << RAM_ADDR_BITS;

    // master out reg, one reg per node, master in reg, then done reg.
    localparam int RING_LATENCY = NUM_RAMS + 2;

    localparam int MAX_INFLIGHT = 4;

endpackage
